// File: hdl/rst_interval_timer.sv
/*
 * Loadable down-counter for the hold intervals.
 * After a load of N, done_o is sampled high on the N-th following edge.
 * A load of 0 leaves the timer idle; load wins over counting.
 */
`default_nettype none

module rst_interval_timer
  import usbphy_rst_pkg::*;
(
  input  logic       phy_refclock,
  input  logic       rst_n_i,
  input  logic       load_i,
  input  rst_count_t value_i,
  output logic       done_o
);

  rst_count_t count_q;

  // ---------------------------------------------------------------------------
  // Counter
  // ---------------------------------------------------------------------------

  always_ff @(posedge phy_refclock or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      count_q <= '0;
    end
    else if (load_i)
    begin
      count_q <= value_i;
    end
    else if (count_q != '0)
    begin
      count_q <= count_q - rst_count_t'(1);
    end
  end

  // Last cycle of the interval, low when idle
  assign done_o = (count_q == rst_count_t'(1));

endmodule

`default_nettype wire

// File: hdl/rst_release_chain.sv
/*
 * Release chain for one PHY reset output. STAGES must be 2 or more.
 * Asserts on the first edge after req_i rises, releases STAGES edges after
 * it falls. In scan mode the output is rst_n_i at the output polarity.
 */
`default_nettype none

module rst_release_chain #(
  parameter int STAGES      = 2,
  parameter bit ACTIVE_HIGH = 1'b1
) (
  input  logic phy_refclock,
  input  logic rst_n_i,
  input  logic scan_mode_i,
  input  logic req_i,
  output logic rst_o
);

  localparam logic ASSERTED = ACTIVE_HIGH;

  logic [STAGES-1:0] chain_q;

  // ---------------------------------------------------------------------------
  // Shift chain
  // ---------------------------------------------------------------------------

  always_ff @(posedge phy_refclock or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      chain_q <= {STAGES{ASSERTED}};
    end
    else if (req_i)
    begin
      // Whole chain reloads so assertion takes one edge
      chain_q <= {STAGES{ASSERTED}};
    end
    else
    begin
      chain_q <= {chain_q[STAGES-2:0], ~ASSERTED};
    end
  end

  // Scan bypass
  assign rst_o = scan_mode_i ? (ACTIVE_HIGH ? ~rst_n_i : rst_n_i)
                             : chain_q[STAGES-1];

endmodule

`default_nettype wire

// File: hdl/rst_seq_fsm.sv
/*
 * Orders the PHY reset releases: pon, phyrst, dbus, tsfr, then ready.
 * Each request drops after exactly its hold interval. Commands are taken
 * only in S_READY, once the transceiver reset chain has released.
 */
`default_nettype none

`include "usbphy_rst_params.svh"

module rst_seq_fsm
  import usbphy_rst_pkg::*;
(
  input  logic       phy_refclock,
  input  logic       rst_n_i,
  input  logic       timer_done_i,
  output logic       timer_load_o,
  output rst_count_t timer_value_o,
  input  logic       cmd_valid_i,
  input  rst_cmd_t   cmd_i,
  output logic       cmd_ready_o,
  output logic       pon_req_o,
  output logic       phyrst_req_o,
  output logic       dbus_req_o,
  output logic       tsfr_req_o
);

  localparam int REL_STAGES = `USBPHY_RST_RELEASE_STAGES;

  rst_seq_state_t        state_q;
  rst_seq_state_t        state_d;
  logic                  start_q;
  logic                  step_done;
  logic                  cmd_fire;
  logic [REL_STAGES-1:0] ready_sr;
  logic                  pon_req_q;
  logic                  phyrst_req_q;
  logic                  dbus_req_q;
  logic                  tsfr_req_q;

  // Hold interval of a step
  function automatic rst_count_t hold_cycles(rst_seq_state_t st);
    rst_count_t cycles;
    case (st)
      S_PON:    cycles = rst_count_t'(`USBPHY_RST_PON_CYCLES);
      S_PHYRST: cycles = rst_count_t'(`USBPHY_RST_PHYRST_CYCLES);
      S_DBUS:   cycles = rst_count_t'(`USBPHY_RST_DBUS_CYCLES);
      S_TSFR:   cycles = rst_count_t'(`USBPHY_RST_TSFR_CYCLES);
      default:  cycles = '0;
    endcase
    return cycles;
  endfunction

  assign step_done = timer_done_i && (state_q != S_READY);
  assign cmd_fire  = cmd_valid_i && cmd_ready_o;

  // ---------------------------------------------------------------------------
  // Next state
  // ---------------------------------------------------------------------------

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_PON:
        if (timer_done_i)
          state_d = S_PHYRST;
      S_PHYRST:
        if (timer_done_i)
          state_d = S_DBUS;
      S_DBUS:
        if (timer_done_i)
          state_d = S_TSFR;
      S_TSFR:
        if (timer_done_i)
          state_d = S_READY;
      S_READY:
        if (cmd_fire)
          state_d = (cmd_i == CMD_FULL_RESTART) ? S_PHYRST : S_DBUS;
      default:
        state_d = S_PON;
    endcase
  end

  // Timer loads on every step entry
  // The first edge out of reset already counts toward the power-on hold
  assign timer_load_o  = start_q || step_done || cmd_fire;
  assign timer_value_o = start_q ? hold_cycles(S_PON) - rst_count_t'(1)
                                 : hold_cycles(state_d);

  // ---------------------------------------------------------------------------
  // State and request registers
  // ---------------------------------------------------------------------------

  always_ff @(posedge phy_refclock or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q      <= S_PON;
      start_q      <= 1'b1;
      pon_req_q    <= 1'b1;
      phyrst_req_q <= 1'b1;
      dbus_req_q   <= 1'b1;
      tsfr_req_q   <= 1'b1;
    end
    else
    begin
      state_q      <= state_d;
      start_q      <= 1'b0;
      pon_req_q    <= (state_d == S_PON);
      phyrst_req_q <= (state_d == S_PON) || (state_d == S_PHYRST);
      dbus_req_q   <= (state_d != S_TSFR) && (state_d != S_READY);
      tsfr_req_q   <= (state_d != S_READY);
    end
  end

  // Ready waits for the transceiver reset to leave its release chain
  always_ff @(posedge phy_refclock or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ready_sr <= '0;
    end
    else if (state_q == S_READY)
    begin
      ready_sr <= {ready_sr[REL_STAGES-2:0], 1'b1};
    end
    else
    begin
      ready_sr <= '0;
    end
  end

  assign cmd_ready_o  = (state_q == S_READY) && ready_sr[REL_STAGES-1];
  assign pon_req_o    = pon_req_q;
  assign phyrst_req_o = phyrst_req_q;
  assign dbus_req_o   = dbus_req_q;
  assign tsfr_req_o   = tsfr_req_q;

endmodule

`default_nettype wire

// File: hdl/rst_sync.sv
/*
 * Internal active-low reset from the pin reset and the software reset level.
 * Pin reset asserts asynchronously, software reset on the next edge; both
 * release SYNC_STAGES edges after they fall away. Scan mode passes reset.
 */
`default_nettype none

`include "usbphy_rst_params.svh"

module rst_sync (
  input  logic phy_refclock,
  input  logic reset,
  input  logic scan_mode_i,
  input  logic swrst_i,
  output logic rst_n_o
);

  localparam int SYNC_STAGES = `USBPHY_RST_SYNC_STAGES;

  logic [SYNC_STAGES-1:0] sync_ff;
  logic [SYNC_STAGES-1:0] swrst_ff;
  logic                   rst_n_func;

  // Release synchronizer for the pin reset
  always_ff @(posedge phy_refclock or negedge reset)
  begin
    if (!reset)
    begin
      sync_ff <= '0;
    end
    else
    begin
      sync_ff <= {sync_ff[SYNC_STAGES-2:0], 1'b1};
    end
  end

  // Software reset stretcher
  // Held released under pin reset so only swrst_i clears it
  always_ff @(posedge phy_refclock or negedge reset)
  begin
    if (!reset)
    begin
      swrst_ff <= '1;
    end
    else if (swrst_i)
    begin
      swrst_ff <= '0;
    end
    else
    begin
      swrst_ff <= {swrst_ff[SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign rst_n_func = sync_ff[SYNC_STAGES-1] & swrst_ff[SYNC_STAGES-1];

  // Scan bypass
  assign rst_n_o = scan_mode_i ? reset : rst_n_func;

endmodule

`default_nettype wire

// File: hdl/usbphy_rst_params.svh
/*
 * Timing of the PHY reset sequence, in phy_refclock cycles.
 * Hold intervals must be at least 2 and fit in USBPHY_RST_TIMER_W bits.
 * Stage counts must be at least 2.
 */
`ifndef USBPHY_RST_PARAMS_SVH
`define USBPHY_RST_PARAMS_SVH

// ---------------------------------------------------------------------------
// Flop chains
// ---------------------------------------------------------------------------

// Reset synchronizer and software reset stretcher depth
`define USBPHY_RST_SYNC_STAGES 2

// Depth of every output release chain
`define USBPHY_RST_RELEASE_STAGES 2

// ---------------------------------------------------------------------------
// Hold intervals of the sequence steps
// ---------------------------------------------------------------------------

`define USBPHY_RST_PON_CYCLES 16
`define USBPHY_RST_PHYRST_CYCLES 12
`define USBPHY_RST_DBUS_CYCLES 8
`define USBPHY_RST_TSFR_CYCLES 4

// Interval timer width
`define USBPHY_RST_TIMER_W 8

`endif

// File: hdl/usbphy_rst_pkg.sv
/*
 * Types shared by the PHY reset sequencer blocks.
 * Timer width comes from the params header.
 */
`default_nettype none

`include "usbphy_rst_params.svh"

package usbphy_rst_pkg;

  // Timer load and count value
  typedef logic [`USBPHY_RST_TIMER_W-1:0] rst_count_t;

  // Restart command on the valid/ready channel
  typedef enum logic {
    CMD_FULL_RESTART = 1'b0,
    CMD_DBUS_RESET   = 1'b1
  } rst_cmd_t;

  // Sequencer steps, in release order
  typedef enum logic [2:0] {
    S_PON    = 3'd0,
    S_PHYRST = 3'd1,
    S_DBUS   = 3'd2,
    S_TSFR   = 3'd3,
    S_READY  = 3'd4
  } rst_seq_state_t;

endpackage

`default_nettype wire

// File: hdl/usbphy_rst_top.sv
/*
 * PHY side reset and power-up sequencing, all on phy_refclock.
 * warst_i is ORed into phy_reset_o without a clock, outside scan mode.
 * cmd_valid_i and cmd_i must stay stable while cmd_ready_o is low.
 */
`default_nettype none

`include "usbphy_rst_params.svh"

module usbphy_rst_top
  import usbphy_rst_pkg::*;
(
  input  logic     phy_refclock,
  input  logic     reset,
  input  logic     scan_mode_i,
  input  logic     swrst_i,
  input  logic     warst_i,
  input  logic     cmd_valid_i,
  input  rst_cmd_t cmd_i,
  output logic     cmd_ready_o,
  output logic     phy_ponrst_o,
  output logic     phy_reset_o,
  output logic     phy_databus_reset_o,
  output logic     tsfr_rstb_o,
  output logic     core_rst_n_o
);

  localparam int REL_STAGES = `USBPHY_RST_RELEASE_STAGES;

  logic       rst_n_int;
  logic       timer_load;
  rst_count_t timer_value;
  logic       timer_done;
  logic       pon_req;
  logic       phyrst_req;
  logic       dbus_req;
  logic       tsfr_req;
  logic       phy_reset_chain;

  // ---------------------------------------------------------------------------
  // Internal reset, timer and sequencer
  // ---------------------------------------------------------------------------

  rst_sync u_rst_sync (
    .phy_refclock (phy_refclock),
    .reset        (reset),
    .scan_mode_i  (scan_mode_i),
    .swrst_i      (swrst_i),
    .rst_n_o      (rst_n_int)
  );

  rst_interval_timer u_timer (
    .phy_refclock (phy_refclock),
    .rst_n_i      (rst_n_int),
    .load_i       (timer_load),
    .value_i      (timer_value),
    .done_o       (timer_done)
  );

  rst_seq_fsm u_seq_fsm (
    .phy_refclock  (phy_refclock),
    .rst_n_i       (rst_n_int),
    .timer_done_i  (timer_done),
    .timer_load_o  (timer_load),
    .timer_value_o (timer_value),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .cmd_ready_o   (cmd_ready_o),
    .pon_req_o     (pon_req),
    .phyrst_req_o  (phyrst_req),
    .dbus_req_o    (dbus_req),
    .tsfr_req_o    (tsfr_req)
  );

  // ---------------------------------------------------------------------------
  // Release chains, one per PHY reset
  // ---------------------------------------------------------------------------

  // Power-on reset, active low
  rst_release_chain #(.STAGES(REL_STAGES), .ACTIVE_HIGH(1'b0)) u_pon_chain (
    .phy_refclock (phy_refclock),
    .rst_n_i      (rst_n_int),
    .scan_mode_i  (scan_mode_i),
    .req_i        (pon_req),
    .rst_o        (phy_ponrst_o)
  );

  rst_release_chain #(.STAGES(REL_STAGES), .ACTIVE_HIGH(1'b1)) u_phyrst_chain (
    .phy_refclock (phy_refclock),
    .rst_n_i      (rst_n_int),
    .scan_mode_i  (scan_mode_i),
    .req_i        (phyrst_req),
    .rst_o        (phy_reset_chain)
  );

  rst_release_chain #(.STAGES(REL_STAGES), .ACTIVE_HIGH(1'b1)) u_dbus_chain (
    .phy_refclock (phy_refclock),
    .rst_n_i      (rst_n_int),
    .scan_mode_i  (scan_mode_i),
    .req_i        (dbus_req),
    .rst_o        (phy_databus_reset_o)
  );

  // Transceiver reset, active low
  rst_release_chain #(.STAGES(REL_STAGES), .ACTIVE_HIGH(1'b0)) u_tsfr_chain (
    .phy_refclock (phy_refclock),
    .rst_n_i      (rst_n_int),
    .scan_mode_i  (scan_mode_i),
    .req_i        (tsfr_req),
    .rst_o        (tsfr_rstb_o)
  );

  // Warm reset hits the PHY reset at once
  assign phy_reset_o  = phy_reset_chain | (warst_i & ~scan_mode_i);
  assign core_rst_n_o = rst_n_int;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f usbphy_rst_top.f \
  --top-module usbphy_rst_tb \
  -o usbphy_rst_sim

status=0
out=$(./obj_dir/usbphy_rst_sim) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -q '^ALL CHECKS PASSED$'; then
  exit 0
fi
exit 1

// File: sim/usbphy_rst_assertions.sv
/*
 * Ordering and handshake checks for usbphy_rst_top.
 * Idle while the core reset is low and in scan mode.
 */
`default_nettype none

module usbphy_rst_assertions
  import usbphy_rst_pkg::*;
(
  input logic     phy_refclock,
  input logic     scan_mode_i,
  input logic     core_rst_n_o,
  input logic     cmd_valid_i,
  input rst_cmd_t cmd_i,
  input logic     cmd_ready_o,
  input logic     phy_ponrst_o,
  input logic     phy_reset_chain,
  input logic     phy_databus_reset_o,
  input logic     tsfr_rstb_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Later resets never release ahead of earlier ones
  a_release_order: assert property (@(posedge phy_refclock)
    disable iff (!core_rst_n_o || scan_mode_i)
    (phy_ponrst_o || phy_reset_chain) && (!phy_reset_chain || phy_databus_reset_o)
    && (!tsfr_rstb_o || !phy_databus_reset_o))
    else $error("reset release order violated");

  // Ready only once every PHY reset is released
  a_ready_released: assert property (@(posedge phy_refclock)
    disable iff (!core_rst_n_o || scan_mode_i)
    cmd_ready_o |-> (phy_ponrst_o && !phy_reset_chain && !phy_databus_reset_o
                     && tsfr_rstb_o))
    else $error("cmd_ready_o high while a reset is asserted");

  // Back-pressure keeps the command stable
  a_cmd_stable: assert property (@(posedge phy_refclock)
    disable iff (!core_rst_n_o || scan_mode_i)
    (cmd_valid_i && !cmd_ready_o) |=> (cmd_valid_i && $stable(cmd_i)))
    else $error("command changed while stalled");

endmodule

bind usbphy_rst_top usbphy_rst_assertions u_assertions (
  .phy_refclock        (phy_refclock),
  .scan_mode_i         (scan_mode_i),
  .core_rst_n_o        (core_rst_n_o),
  .cmd_valid_i         (cmd_valid_i),
  .cmd_i               (cmd_i),
  .cmd_ready_o         (cmd_ready_o),
  .phy_ponrst_o        (phy_ponrst_o),
  .phy_reset_chain     (phy_reset_chain),
  .phy_databus_reset_o (phy_databus_reset_o),
  .tsfr_rstb_o         (tsfr_rstb_o)
);

`default_nettype wire

// File: sim/usbphy_rst_tb.sv
/*
 * Directed testbench for usbphy_rst_top.
 * Release times are counted in clock edges from the stimulus edge.
 */
`default_nettype none

`include "usbphy_rst_params.svh"

module usbphy_rst_tb
  import usbphy_rst_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SYNC = `USBPHY_RST_SYNC_STAGES;
  localparam int REL = `USBPHY_RST_RELEASE_STAGES;
  localparam int PON = `USBPHY_RST_PON_CYCLES;
  localparam int PHYRST = `USBPHY_RST_PHYRST_CYCLES;
  localparam int DBUS = `USBPHY_RST_DBUS_CYCLES;
  localparam int TSFR = `USBPHY_RST_TSFR_CYCLES;
  localparam int SEQ_LIMIT = SYNC + PON + PHYRST + DBUS + TSFR + REL + 8;
  // About eight sequences plus margin, at 8 ns per cycle
  localparam int WATCHDOG_NS = (8 * SEQ_LIMIT + 200) * 8;

  logic phy_refclock = 1'b0;
  logic reset, scan_mode_i, swrst_i, warst_i, cmd_valid_i;
  rst_cmd_t cmd_i;
  logic cmd_ready_o, phy_ponrst_o, phy_reset_o, phy_databus_reset_o;
  logic tsfr_rstb_o, core_rst_n_o;
  int cyc = 0;
  int test_err = 0;
  int total_err = 0;
  int tests = 0;
  int failed_tests = 0;
  logic [7:0] lfsr_q = 8'd31;

  usbphy_rst_top dut (.*);

  always #4 phy_refclock = ~phy_refclock;

  always @(posedge phy_refclock) cyc <= cyc + 1;

  // Fibonacci LFSR, taps 8 6 5 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic int random_gap();
    int gap;
    gap = 0;
    for (int i = 0; i < 3; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      gap = gap * 2 + int'(lfsr_q[0]);
    end
    return gap;
  endfunction

  task automatic tick();
    @(posedge phy_refclock);
    #1;
  endtask

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp)
    else
    begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      test_err++;
    end
  endtask

  // Condition check with a plain error line
  task automatic check_true(input bit ok, input string msg);
    assert (ok)
    else
    begin
      $display("ERROR %s", msg);
      test_err++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s %s", name, (test_err == 0) ? "ok" : "failed");
    tests++;
    total_err += test_err;
    if (test_err != 0)
      failed_tests++;
    test_err = 0;
  endtask

  // Expected levels of all resets, asserted or released
  task automatic check_levels(input bit asserted);
    check_val("phy_ponrst_o", int'(phy_ponrst_o), int'(!asserted));
    check_val("phy_reset_o", int'(phy_reset_o), int'(asserted));
    check_val("phy_databus_reset_o", int'(phy_databus_reset_o), int'(asserted));
    check_val("tsfr_rstb_o", int'(tsfr_rstb_o), int'(!asserted));
  endtask

  // Cycle of each release edge, until cmd_ready_o rises
  task automatic measure(output int t_pon, output int t_phy, output int t_dbus,
                         output int t_tsfr, output int t_rdy, output bit pon_low,
                         output bit phy_high);
    logic p_pon, p_phy, p_dbus, p_tsfr, p_rdy;
    t_pon = -1;
    t_phy = -1;
    t_dbus = -1;
    t_tsfr = -1;
    t_rdy = -1;
    pon_low = 0;
    phy_high = 0;
    for (int n = 0; n < SEQ_LIMIT && t_rdy < 0; n++)
    begin
      p_pon = phy_ponrst_o;
      p_phy = phy_reset_o;
      p_dbus = phy_databus_reset_o;
      p_tsfr = tsfr_rstb_o;
      p_rdy = cmd_ready_o;
      tick();
      if (!p_pon && phy_ponrst_o)
        t_pon = cyc;
      if (p_phy && !phy_reset_o)
        t_phy = cyc;
      if (p_dbus && !phy_databus_reset_o)
        t_dbus = cyc;
      if (!p_tsfr && tsfr_rstb_o)
        t_tsfr = cyc;
      if (!p_rdy && cmd_ready_o)
        t_rdy = cyc;
      if (!phy_ponrst_o)
        pon_low = 1;
      if (phy_reset_o)
        phy_high = 1;
    end
    check_true(t_rdy >= 0, "cmd_ready_o never rose within the sequence limit");
  endtask

  // Offer a command and hold it until it transfers
  task automatic send_cmd(input rst_cmd_t cmd, output int xfer);
    int n;
    @(posedge phy_refclock);
    cmd_valid_i <= 1'b1;
    cmd_i <= cmd;
    #1;
    n = 0;
    while (!cmd_ready_o && n < SEQ_LIMIT)
    begin
      tick();
      n++;
    end
    check_true(n < SEQ_LIMIT, "command was never accepted");
    @(posedge phy_refclock);
    cmd_valid_i <= 1'b0;
    #1;
    xfer = cyc;
  endtask

  task automatic check_full_seq(input int start);
    int t_pon, t_phy, t_dbus, t_tsfr, t_rdy;
    bit pon_low, phy_high;
    measure(t_pon, t_phy, t_dbus, t_tsfr, t_rdy, pon_low, phy_high);
    check_val("phy_ponrst_o release", t_pon - start, SYNC + PON + REL);
    check_val("phy_reset_o release", t_phy - t_pon, PHYRST);
    check_val("phy_databus_reset_o release", t_dbus - t_phy, DBUS);
    check_val("tsfr_rstb_o release", t_tsfr - t_dbus, TSFR);
    check_val("cmd_ready_o rise", t_rdy, t_tsfr);
  endtask

  task automatic test_power_up();
    int start;
    repeat (3) tick();
    check_levels(1'b1);
    check_val("cmd_ready_o", int'(cmd_ready_o), 0);
    @(posedge phy_refclock);
    reset <= 1'b1;
    #1;
    start = cyc;
    check_full_seq(start);
    finish_test("power_up");
  endtask

  task automatic test_full_restart();
    int xfer, t_pon, t_phy, t_dbus, t_tsfr, t_rdy;
    bit pon_low, phy_high;
    repeat (random_gap()) tick();
    send_cmd(CMD_FULL_RESTART, xfer);
    tick();
    check_val("phy_ponrst_o", int'(phy_ponrst_o), 1);
    check_val("phy_reset_o", int'(phy_reset_o), 1);
    check_val("phy_databus_reset_o", int'(phy_databus_reset_o), 1);
    check_val("tsfr_rstb_o", int'(tsfr_rstb_o), 0);
    measure(t_pon, t_phy, t_dbus, t_tsfr, t_rdy, pon_low, phy_high);
    check_val("phy_ponrst_o low seen", int'(pon_low), 0);
    check_val("phy_reset_o release", t_phy - xfer, PHYRST + REL);
    check_val("phy_databus_reset_o release", t_dbus - t_phy, DBUS);
    check_val("tsfr_rstb_o release", t_tsfr - t_dbus, TSFR);
    check_val("cmd_ready_o rise", t_rdy, t_tsfr);
    finish_test("full_restart");
  endtask

  task automatic check_dbus_seq(input int xfer);
    int t_pon, t_phy, t_dbus, t_tsfr, t_rdy;
    bit pon_low, phy_high;
    tick();
    check_val("phy_ponrst_o", int'(phy_ponrst_o), 1);
    check_val("phy_reset_o", int'(phy_reset_o), 0);
    check_val("phy_databus_reset_o", int'(phy_databus_reset_o), 1);
    check_val("tsfr_rstb_o", int'(tsfr_rstb_o), 0);
    measure(t_pon, t_phy, t_dbus, t_tsfr, t_rdy, pon_low, phy_high);
    check_val("phy_ponrst_o low seen", int'(pon_low), 0);
    check_val("phy_reset_o high seen", int'(phy_high), 0);
    check_val("phy_databus_reset_o release", t_dbus - xfer, DBUS + REL);
    check_val("tsfr_rstb_o release", t_tsfr - t_dbus, TSFR);
    check_val("cmd_ready_o rise", t_rdy, t_tsfr);
  endtask

  task automatic test_dbus_reset();
    int xfer;
    repeat (random_gap()) tick();
    send_cmd(CMD_DBUS_RESET, xfer);
    check_dbus_seq(xfer);
    finish_test("dbus_reset");
  endtask

  task automatic test_back_pressure();
    int xfer1, xfer2;
    repeat (random_gap()) tick();
    send_cmd(CMD_FULL_RESTART, xfer1);
    // Second command waits out the whole restart
    send_cmd(CMD_DBUS_RESET, xfer2);
    check_val("accept cycle", xfer2 - xfer1, PHYRST + DBUS + TSFR + REL + 1);
    check_dbus_seq(xfer2);
    for (int n = 0; n < 16; n++)
    begin
      tick();
      check_true(cmd_ready_o && !phy_databus_reset_o,
                 "an extra restart followed the held command");
    end
    finish_test("back_pressure");
  endtask

  task automatic test_sw_warm_reset();
    int start;
    @(posedge phy_refclock);
    swrst_i <= 1'b1;
    #1;
    tick();
    check_levels(1'b1);
    check_val("core_rst_n_o", int'(core_rst_n_o), 0);
    check_val("cmd_ready_o", int'(cmd_ready_o), 0);
    repeat (3) tick();
    @(posedge phy_refclock);
    swrst_i <= 1'b0;
    #1;
    start = cyc;
    check_full_seq(start);
    @(posedge phy_refclock);
    warst_i <= 1'b1;
    #1;
    check_val("phy_reset_o", int'(phy_reset_o), 1);
    check_val("phy_ponrst_o", int'(phy_ponrst_o), 1);
    check_val("phy_databus_reset_o", int'(phy_databus_reset_o), 0);
    check_val("tsfr_rstb_o", int'(tsfr_rstb_o), 1);
    check_val("core_rst_n_o", int'(core_rst_n_o), 1);
    @(posedge phy_refclock);
    warst_i <= 1'b0;
    #1;
    check_val("phy_reset_o", int'(phy_reset_o), 0);
    finish_test("sw_warm_reset");
  endtask

  task automatic test_scan_mode();
    @(posedge phy_refclock);
    scan_mode_i <= 1'b1;
    #1;
    check_levels(1'b0);
    @(posedge phy_refclock);
    reset <= 1'b0;
    #1;
    check_levels(1'b1);
    check_val("core_rst_n_o", int'(core_rst_n_o), 0);
    @(posedge phy_refclock);
    reset <= 1'b1;
    #1;
    check_levels(1'b0);
    check_val("core_rst_n_o", int'(core_rst_n_o), 1);
    @(posedge phy_refclock);
    scan_mode_i <= 1'b0;
    #1;
    finish_test("scan_mode");
  endtask

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("ERROR watchdog expired before the tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    reset = 1'b0;
    scan_mode_i = 1'b0;
    swrst_i = 1'b0;
    warst_i = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i = CMD_FULL_RESTART;
    test_power_up();
    test_full_restart();
    test_dbus_reset();
    test_back_pressure();
    test_sw_warm_reset();
    test_scan_mode();
    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, total_err);
    if (total_err == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: usbphy_rst_top.f
+incdir+hdl
hdl/usbphy_rst_pkg.sv
hdl/rst_sync.sv
hdl/rst_interval_timer.sv
hdl/rst_seq_fsm.sv
hdl/rst_release_chain.sv
hdl/usbphy_rst_top.sv
sim/usbphy_rst_assertions.sv
sim/usbphy_rst_tb.sv
